/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_soc_fpga_wrapper
FILELIST := sim.f
BUILD    := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* dv/tb_soc_fpga_wrapper.sv */
`timescale 1ns/1ps

module tb_soc_fpga_wrapper import soc_pkg::*; ();

   localparam int FRAME_CLKS    = 10 * CLKS_PER_BIT;
   localparam int WATCHDOG_CLKS = 4000 * FRAME_CLKS;

   logic        clk_i;
   logic        rst_i;
   logic        uart_rxd_i;
   logic        uart_txd_o;
   logic        trap_o;
   logic [31:0] rng_state;
   // Expected register contents
   byte_t       exp_regs [REG_COUNT];

   soc_fpga_wrapper u_soc_fpga_wrapper (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .uart_rxd_i(uart_rxd_i),
      .uart_txd_o(uart_txd_o),
      .trap_o    (trap_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         report_failure($sformatf("Mismatch at %0t: %s got %0h, expected %0h",
                                  $time, name, actual, expected));
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic rand_byte(output byte_t b);
      rng_state = xorshift32(rng_state);
      b = rng_state[7:0];
   endtask

   // 8N1 frame, start bit first and data LSB first
   task automatic send_byte(input byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk_i);
         uart_rxd_i <= frame[i];
         repeat (CLKS_PER_BIT - 1) @(posedge clk_i);
      end
   endtask

   task automatic recv_byte(output byte_t b);
      int waited;
      waited = 0;
      @(negedge clk_i);
      while (uart_txd_o !== 1'b0) begin
         if (waited == 4 * FRAME_CLKS) begin
            report_failure("No UART frame arrived from the DUT");
         end
         waited++;
         @(negedge clk_i);
      end
      // Move to the middle of the start bit
      repeat (CLKS_PER_BIT / 2) @(negedge clk_i);
      check("uart_txd_o start bit", uart_txd_o, 1'b0);
      for (int i = 0; i < 8; i++) begin
         repeat (CLKS_PER_BIT) @(negedge clk_i);
         b[i] = uart_txd_o;
      end
      repeat (CLKS_PER_BIT) @(negedge clk_i);
      check("uart_txd_o stop bit", uart_txd_o, 1'b1);
   endtask

   task automatic write_reg(input byte_t addr, input byte_t data);
      send_byte(OP_WRITE);
      send_byte(addr);
      send_byte(data);
      exp_regs[addr[3:0]] = data;
   endtask

   task automatic read_check(input byte_t addr);
      byte_t got;
      send_byte(OP_READ);
      send_byte(addr);
      recv_byte(got);
      check($sformatf("read data at address %0h", addr), got, exp_regs[addr[3:0]]);
   endtask

   // Board reset for 10 cycles, outputs watched during and after it
   task automatic apply_reset();
      for (int i = 0; i < 10 + 2 * (RST_START + RST_DURATION); i++) begin
         @(posedge clk_i);
         rst_i      <= (i < 10);
         uart_rxd_i <= 1'b1;
         @(negedge clk_i);
         if (i > 0) begin
            check("uart_txd_o", uart_txd_o, 1'b1);
            check("trap_o", trap_o, 1'b0);
         end
      end
      for (int a = 0; a < REG_COUNT; a++) begin
         exp_regs[a] = '0;
      end
   endtask

   task automatic test_reset_outputs();
      apply_reset();
   endtask

   task automatic test_write_read_all();
      byte_t d;
      for (int a = 0; a < REG_COUNT; a++) begin
         rand_byte(d);
         write_reg(8'(a), d);
      end
      for (int a = 0; a < REG_COUNT; a++) begin
         read_check(8'(a));
      end
   endtask

   task automatic test_cleared_after_reset();
      apply_reset();
      for (int a = 0; a < REG_COUNT; a++) begin
         read_check(8'(a));
      end
   endtask

   task automatic test_address_wrap();
      byte_t r;
      byte_t d;
      for (int k = 0; k < 4; k++) begin
         rand_byte(r);
         rand_byte(d);
         // Upper nibble forced nonzero, only the low nibble selects
         write_reg({r[7:4] | 4'h1, r[3:0]}, d);
         read_check({4'h0, r[3:0]});
         read_check({~r[7:4] | 4'h8, r[3:0]});
      end
   endtask

   task automatic test_illegal_opcode();
      byte_t op;
      byte_t addr;
      op = OP_WRITE;
      while (op == OP_WRITE || op == OP_READ) begin
         rand_byte(op);
      end
      send_byte(op);
      rand_byte(addr);
      send_byte(OP_READ);
      send_byte(addr);
      // Trapped engine must stay silent
      repeat (3 * FRAME_CLKS) begin
         @(negedge clk_i);
         check("trap_o", trap_o, 1'b1);
         check("uart_txd_o", uart_txd_o, 1'b1);
      end
   endtask

   task automatic test_trap_clear();
      byte_t addr;
      byte_t d;
      apply_reset();
      rand_byte(addr);
      rand_byte(d);
      write_reg({4'h0, addr[3:0]}, d);
      read_check({4'h0, addr[3:0]});
      check("trap_o", trap_o, 1'b0);
   endtask

   initial begin
      rst_i      = 1'b1;
      uart_rxd_i = 1'b1;
      rng_state  = 32'h51be;
      test_reset_outputs();
      test_write_read_all();
      test_cleared_after_reset();
      test_address_wrap();
      test_illegal_opcode();
      test_trap_clear();
      $display("ALL CHECKS PASSED");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CLKS) @(posedge clk_i);
      report_failure("Timeout, the tests did not finish in time");
   end

endmodule

/* hdl/cmd_engine.sv */
`timescale 1ns/1ps

module cmd_engine import soc_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,
   input  uart_byte_t rx_byte_i,
   input  logic       tx_busy_i,
   output uart_byte_t tx_req_o,
   output logic       trap_o
);

   cmd_state_t state_q;
   logic       is_write_q;
   reg_addr_t  addr_q;
   byte_t      rd_data_q;
   byte_t      regs_q [REG_COUNT];

   // Opcode, address and data parsing
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q    <= IDLE;
         is_write_q <= 1'b0;
         for (int i = 0; i < REG_COUNT; i++) begin
            regs_q[i] <= '0;
         end
      end else begin
         case (state_q)
            IDLE: begin
               if (rx_byte_i.valid) begin
                  if (rx_byte_i.data == OP_WRITE) begin
                     is_write_q <= 1'b1;
                     state_q    <= GET_ADDR;
                  end else if (rx_byte_i.data == OP_READ) begin
                     is_write_q <= 1'b0;
                     state_q    <= GET_ADDR;
                  end else begin
                     state_q <= TRAPPED;
                  end
               end
            end
            GET_ADDR: begin
               if (rx_byte_i.valid) begin
                  state_q <= is_write_q ? GET_DATA : SEND;
               end
            end
            GET_DATA: begin
               if (rx_byte_i.valid) begin
                  regs_q[addr_q] <= rx_byte_i.data;
                  state_q        <= IDLE;
               end
            end
            SEND: begin
               // Request goes out this cycle if the line is free
               if (!tx_busy_i) begin
                  state_q <= WAIT_TX;
               end
            end
            WAIT_TX: begin
               if (!tx_busy_i) begin
                  state_q <= IDLE;
               end
            end
            TRAPPED: state_q <= TRAPPED;
            default: state_q <= IDLE;
         endcase
      end
   end

   // Address capture and read data fetch
   always_ff @(posedge clk_i) begin
      if (state_q == GET_ADDR && rx_byte_i.valid) begin
         addr_q    <= rx_byte_i.data[3:0];
         rd_data_q <= regs_q[rx_byte_i.data[3:0]];
      end
   end

   assign tx_req_o.valid = (state_q == SEND) && !tx_busy_i;
   assign tx_req_o.data  = rd_data_q;

   // Sticky until reset
   assign trap_o = (state_q == TRAPPED);

   a_trap_sticky: assert property (
      @(posedge clk_i) $fell(trap_o) |-> $past(rst_i)
   ) else $error("trap cleared without reset");

endmodule

/* hdl/por_pulse_gen.sv */
`timescale 1ns/1ps

module por_pulse_gen import soc_pkg::*; (
   input  logic clk_i,
   input  logic rst_i,
   output logic core_rst_o
);

   // Total cycles the core reset outlives the board reset
   localparam int PULSE_LEN = RST_START + RST_DURATION;
   localparam int CNT_W     = $clog2(PULSE_LEN + 1);

   logic [CNT_W-1:0] cnt_q;

   // Counter restarts on board reset and saturates at the pulse length
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cnt_q <= '0;
      end else if (cnt_q != CNT_W'(PULSE_LEN)) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // Held while board reset is up, then for PULSE_LEN more cycles
   assign core_rst_o = rst_i || (cnt_q != CNT_W'(PULSE_LEN));

   // Core reset ends exactly PULSE_LEN cycles after board reset falls
   a_pulse_length: assert property (
      @(posedge clk_i) $fell(core_rst_o) |->
         $past(rst_i, PULSE_LEN + 1) && !$past(rst_i, PULSE_LEN)
   ) else $error("core reset pulse has the wrong length");

endmodule

/* hdl/soc_fpga_wrapper.sv */
`timescale 1ns/1ps

module soc_fpga_wrapper import soc_pkg::*; (
   input  logic clk_i,
   input  logic rst_i,
   input  logic uart_rxd_i,
   output logic uart_txd_o,
   output logic trap_o
);

   logic       core_rst;
   uart_byte_t rx_byte;
   uart_byte_t tx_req;
   logic       tx_busy;

   // Board reset turned into a clean fixed-length core reset
   por_pulse_gen u_por (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .core_rst_o(core_rst)
   );

   uart_rx u_uart_rx (
      .clk_i    (clk_i),
      .rst_i    (core_rst),
      .rxd_i    (uart_rxd_i),
      .rx_byte_o(rx_byte)
   );

   uart_tx u_uart_tx (
      .clk_i   (clk_i),
      .rst_i   (core_rst),
      .tx_req_i(tx_req),
      .txd_o   (uart_txd_o),
      .busy_o  (tx_busy)
   );

   cmd_engine u_cmd_engine (
      .clk_i    (clk_i),
      .rst_i    (core_rst),
      .rx_byte_i(rx_byte),
      .tx_busy_i(tx_busy),
      .tx_req_o (tx_req),
      .trap_o   (trap_o)
   );

endmodule

/* hdl/soc_pkg.sv */
package soc_pkg;

   // UART bit period in core clocks, small so simulation stays short
   localparam int CLKS_PER_BIT = 8;

   // Core reset pulse shaping after board reset release
   localparam int RST_START    = 5;
   localparam int RST_DURATION = 10;

   // Register file depth
   localparam int REG_COUNT = 16;

   // Plain data byte
   typedef logic [7:0] byte_t;

   // Register index
   typedef logic [3:0] reg_addr_t;

   // Command opcodes, ASCII 'W' and 'R'
   localparam byte_t OP_WRITE = 8'h57;
   localparam byte_t OP_READ  = 8'h52;

   // Byte strobe between UART and command engine
   typedef struct packed {
      logic  valid;
      byte_t data;
   } uart_byte_t;

   // Command engine states
   typedef enum logic [2:0] {
      IDLE,
      GET_ADDR,
      GET_DATA,
      SEND,
      WAIT_TX,
      TRAPPED
   } cmd_state_t;

endpackage

/* hdl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx import soc_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       rxd_i,
   output uart_byte_t rx_byte_o
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);

   logic             rxd_meta_q;
   logic             rxd_sync_q;
   logic             busy_q;
   logic [CNT_W-1:0] clk_cnt_q;
   logic [3:0]       bit_idx_q;
   byte_t            shift_q;
   logic             valid_q;

   // Two-flop synchronizer, idles high like the line
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rxd_meta_q <= 1'b1;
         rxd_sync_q <= 1'b1;
      end else begin
         rxd_meta_q <= rxd_i;
         rxd_sync_q <= rxd_meta_q;
      end
   end

   // Bit 0 is the start bit, 1 to 8 data, 9 the stop bit
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy_q    <= 1'b0;
         clk_cnt_q <= '0;
         bit_idx_q <= '0;
         valid_q   <= 1'b0;
      end else begin
         valid_q <= 1'b0;
         if (!busy_q) begin
            if (!rxd_sync_q) begin
               // Half a bit to land in the middle of the start bit
               busy_q    <= 1'b1;
               clk_cnt_q <= CNT_W'(CLKS_PER_BIT / 2 - 1);
               bit_idx_q <= '0;
            end
         end else if (clk_cnt_q != '0) begin
            clk_cnt_q <= clk_cnt_q - 1'b1;
         end else begin
            clk_cnt_q <= CNT_W'(CLKS_PER_BIT - 1);
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 4'd0 && rxd_sync_q) begin
               busy_q <= 1'b0;  // glitch, not a real start bit
            end else if (bit_idx_q == 4'd9) begin
               busy_q  <= 1'b0;
               // Framing error drops the byte
               valid_q <= rxd_sync_q;
            end
         end
      end
   end

   // Data bits arrive LSB first
   always_ff @(posedge clk_i) begin
      if (busy_q && clk_cnt_q == '0 && bit_idx_q != 4'd0 && bit_idx_q != 4'd9) begin
         shift_q <= {rxd_sync_q, shift_q[7:1]};
      end
   end

   assign rx_byte_o.valid = valid_q;
   assign rx_byte_o.data  = shift_q;

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx import soc_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,
   input  uart_byte_t tx_req_i,
   output logic       txd_o,
   output logic       busy_o
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);

   logic [9:0]       shift_q;
   logic [CNT_W-1:0] clk_cnt_q;
   logic [3:0]       bits_left_q;
   logic             busy_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         shift_q     <= '1;
         clk_cnt_q   <= '0;
         bits_left_q <= '0;
         busy_q      <= 1'b0;
      end else if (!busy_q) begin
         if (tx_req_i.valid) begin
            // Stop bit, data LSB first, start bit at the bottom
            shift_q     <= {1'b1, tx_req_i.data, 1'b0};
            clk_cnt_q   <= CNT_W'(CLKS_PER_BIT - 1);
            bits_left_q <= 4'd9;
            busy_q      <= 1'b1;
         end
      end else if (clk_cnt_q != '0) begin
         clk_cnt_q <= clk_cnt_q - 1'b1;
      end else if (bits_left_q == '0) begin
         // End of stop bit
         busy_q <= 1'b0;
      end else begin
         shift_q     <= {1'b1, shift_q[9:1]};
         clk_cnt_q   <= CNT_W'(CLKS_PER_BIT - 1);
         bits_left_q <= bits_left_q - 1'b1;
      end
   end

   // Shifting in ones keeps the line high between frames
   assign txd_o  = shift_q[0];
   assign busy_o = busy_q;

   // Sender must hold off until the frame is out
   a_no_req_when_busy: assert property (
      @(posedge clk_i) disable iff (rst_i) tx_req_i.valid |-> !busy_o
   ) else $error("transmit request while busy");

endmodule

/* sim.f */
hdl/soc_pkg.sv
hdl/por_pulse_gen.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/cmd_engine.sv
hdl/soc_fpga_wrapper.sv
dv/tb_soc_fpga_wrapper.sv
